//--- compile.f
hw/hl_core_pkg.sv
hw/sync_fifo.sv
hw/host_cmd_parser.sv
hw/link_cmd_rx.sv
hw/cmd_bus_arbiter.sv
hw/radio_ctrl_regs.sv
hw/hl_core_top.sv
verification/tb_hl_core.sv

//--- Makefile
# Verilator build and run for the command path testbench

VERILATOR ?= verilator
TOP       ?= tb_hl_core
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "test passed" || \
		(echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tb_hl_core.sv
/*
  Directed testbench for the transceiver command path.
  Drives host and link command frames and checks the register
  outputs and the readback responses.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_hl_core
  import hl_core_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 200;
  localparam int OBS_RUN        = 0;
  localparam int OBS_TX_ON      = 1;
  localparam int OBS_LED        = 2;
  localparam int OBS_RESP_VALID = 3;
  localparam logic [CMD_ADDR_W-1:0] ADDR_UNMAPPED = 6'h3F;

  logic       clk_ctrl;
  logic       reset_i;
  logic [7:0] host_byte_i;
  logic       host_byte_valid_i;
  logic [1:0] linkrx_i;
  logic       tx_inhibit_i;
  logic       resp_pop_i;
  logic       run_o;
  logic       tx_on_o;
  logic [3:0] led_o;
  logic       resp_valid_o;
  resp_t      resp_o;

  int         mismatch_cnt;
  int         timeout_cnt;
  logic [3:0] exp_led;

  always #2 clk_ctrl = ~clk_ctrl;

  hl_core_top #(
    .CMD_FIFO_DEPTH  (4),
    .RESP_FIFO_DEPTH (4)
  ) i_hl_core_top (
    .clk_ctrl          (clk_ctrl),
    .reset_i           (reset_i),
    .host_byte_i       (host_byte_i),
    .host_byte_valid_i (host_byte_valid_i),
    .linkrx_i          (linkrx_i),
    .tx_inhibit_i      (tx_inhibit_i),
    .resp_pop_i        (resp_pop_i),
    .run_o             (run_o),
    .tx_on_o           (tx_on_o),
    .led_o             (led_o),
    .resp_valid_o      (resp_valid_o),
    .resp_o            (resp_o)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic cmd_req_t make_cmd(input logic rqst, input logic [CMD_ADDR_W-1:0] addr,
                                        input logic [CMD_DATA_W-1:0] data);
    cmd_req_t cmd;
    cmd.resp_rqst = rqst;
    cmd.addr      = addr;
    cmd.data      = data;
    return cmd;
  endfunction

  // sync, control byte, then data MSB first
  function automatic logic [7:0] host_frame_byte(input cmd_req_t cmd, input int idx);
    case (idx)
      0:       return FRAME_SYNC;
      1:       return {1'b0, cmd.addr, cmd.resp_rqst};
      default: return 8'(cmd.data >> (8 * (5 - idx)));
    endcase
  endfunction

  function automatic logic [31:0] observe(input int sel);
    case (sel)
      OBS_RUN:        return 32'(run_o);
      OBS_TX_ON:      return 32'(tx_on_o);
      OBS_LED:        return 32'(led_o);
      OBS_RESP_VALID: return 32'(resp_valid_o);
      default:        return 32'h0;
    endcase
  endfunction

  task automatic apply_reset();
    reset_i = 1'b1;
    repeat (4) @(posedge clk_ctrl);
    @(negedge clk_ctrl);
    reset_i = 1'b0;
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    assert (actual === expected) else begin
      mismatch_cnt++;
      $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // sampled on falling edges only
  task automatic wait_until(input int sel, input logic [31:0] expected, input string what);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk_ctrl);
      cycles++;
    end while (observe(sel) !== expected && cycles < TIMEOUT_CYCLES);
    assert (observe(sel) === expected) else begin
      timeout_cnt++;
      $display("timeout: gave up after %0d cycles waiting for %s", cycles, what);
    end
  endtask

  task automatic send_host_frame(input cmd_req_t cmd);
    for (int i = 0; i < 6; i++) begin
      @(negedge clk_ctrl);
      host_byte_valid_i = 1'b1;
      host_byte_i       = host_frame_byte(cmd, i);
    end
    @(negedge clk_ctrl);
    host_byte_valid_i = 1'b0;
    host_byte_i       = 8'h00;
  endtask

  task automatic send_noise_bytes();
    logic [7:0] noise [3];
    noise[0] = 8'h00;
    noise[1] = 8'h3C;
    noise[2] = 8'hFF;
    for (int i = 0; i < 3; i++) begin
      @(negedge clk_ctrl);
      host_byte_valid_i = 1'b1;
      host_byte_i       = noise[i];
    end
  endtask

  // last nbits of the command, MSB first
  task automatic send_link_frame(input cmd_req_t cmd, input int nbits);
    logic [LINK_FRAME_BITS-1:0] bits;
    bits = cmd;
    for (int i = 0; i < nbits; i++) begin
      @(negedge clk_ctrl);
      linkrx_i = {1'b1, bits[nbits-1-i]};
    end
    @(negedge clk_ctrl);
    linkrx_i = 2'b00;
  endtask

  // host bytes start late so both frames end on the same edge
  task automatic send_both_frames(input cmd_req_t host_cmd, input cmd_req_t link_cmd);
    logic [LINK_FRAME_BITS-1:0] bits;
    bits = link_cmd;
    for (int i = 0; i < LINK_FRAME_BITS; i++) begin
      @(negedge clk_ctrl);
      linkrx_i = {1'b1, bits[LINK_FRAME_BITS-1-i]};
      if (i >= LINK_FRAME_BITS - 6) begin
        host_byte_valid_i = 1'b1;
        host_byte_i       = host_frame_byte(host_cmd, i - (LINK_FRAME_BITS - 6));
      end
    end
    @(negedge clk_ctrl);
    linkrx_i          = 2'b00;
    host_byte_valid_i = 1'b0;
    host_byte_i       = 8'h00;
  endtask

  task automatic check_response(input logic [CMD_ADDR_W-1:0] addr,
                                input logic [CMD_DATA_W-1:0] data);
    wait_until(OBS_RESP_VALID, 32'd1, "a response");
    check_value(32'(resp_o.addr), 32'(addr), "response address");
    check_value(resp_o.data, data, "response data");
    @(negedge clk_ctrl);
    resp_pop_i = 1'b1;
    @(negedge clk_ctrl);
    resp_pop_i = 1'b0;
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic test_reset_state();
    check_value(32'(run_o), 32'd0, "run_o after reset");
    check_value(32'(tx_on_o), 32'd0, "tx_on_o after reset");
    check_value(32'(resp_valid_o), 32'd0, "resp_valid_o after reset");
    check_value(32'(led_o), 32'd0, "led_o after reset");
  endtask

  task automatic test_host_writes();
    logic [31:0] led_data;
    led_data = $urandom();
    send_host_frame(make_cmd(1'b0, ADDR_GENERAL, 32'h1));
    wait_until(OBS_RUN, 32'd1, "run_o to rise");
    send_host_frame(make_cmd(1'b1, ADDR_LED, led_data));
    check_response(ADDR_LED, led_data);
    check_value(32'(led_o), 32'(led_data[3:0]), "led_o after host write");
    check_value(32'(resp_valid_o), 32'd0, "resp_valid_o after pop");
    exp_led = led_data[3:0];
  endtask

  task automatic test_link_tx();
    send_link_frame(make_cmd(1'b0, ADDR_TX_CTRL, 32'h1), LINK_FRAME_BITS);
    wait_until(OBS_TX_ON, 32'd1, "tx_on_o to rise");
    tx_inhibit_i = 1'b1;
    wait_until(OBS_TX_ON, 32'd0, "tx_on_o to drop under inhibit");
    tx_inhibit_i = 1'b0;
    wait_until(OBS_TX_ON, 32'd1, "tx_on_o to return");
  endtask

  task automatic test_short_link_and_noise();
    logic [31:0] led_data;
    // leading bit left out, the rest still reads as an LED write
    send_link_frame(make_cmd(1'b0, ADDR_LED, {28'h0, ~exp_led}), LINK_FRAME_BITS - 1);
    // nothing may happen here
    repeat (10) @(negedge clk_ctrl);
    check_value(32'(led_o), 32'(exp_led), "led_o after short link frame");
    led_data = $urandom();
    send_noise_bytes();
    send_host_frame(make_cmd(1'b1, ADDR_LED, led_data));
    check_response(ADDR_LED, led_data);
    check_value(32'(led_o), 32'(led_data[3:0]), "led_o after noisy host frame");
  endtask

  task automatic test_contention_and_unmapped();
    logic [31:0] host_data;
    logic [31:0] link_data;
    host_data      = $urandom();
    link_data      = $urandom();
    link_data[3:0] = host_data[3:0] ^ 4'h5;
    // round-robin turn back at SRC_HOST
    apply_reset();
    send_both_frames(make_cmd(1'b1, ADDR_LED, host_data), make_cmd(1'b1, ADDR_LED, link_data));
    check_response(ADDR_LED, host_data);
    check_response(ADDR_LED, link_data);
    check_value(32'(led_o), 32'(link_data[3:0]), "led_o after contention");
    send_host_frame(make_cmd(1'b1, ADDR_UNMAPPED, $urandom()));
    check_response(ADDR_UNMAPPED, 32'h0);
    check_value(32'(led_o), 32'(link_data[3:0]), "led_o after unmapped write");
  endtask

  initial begin
    clk_ctrl          = 1'b0;
    reset_i           = 1'b1;
    host_byte_i       = 8'h00;
    host_byte_valid_i = 1'b0;
    linkrx_i          = 2'b00;
    tx_inhibit_i      = 1'b0;
    resp_pop_i        = 1'b0;
    mismatch_cnt      = 0;
    timeout_cnt       = 0;
    exp_led           = 4'h0;
    void'($urandom(60));

    apply_reset();
    test_reset_state();
    test_host_writes();
    test_link_tx();
    test_short_link_and_noise();
    test_contention_and_unmapped();

    $display("mismatches: %0d, timeouts: %0d", mismatch_cnt, timeout_cnt);
    if (mismatch_cnt == 0 && timeout_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/hl_core_top.sv
/*
  Transceiver core command path, top level.
  Host and link command sources, their queues, the bus arbiter,
  the radio control registers and the response queue.
*/
`timescale 1ns/1ps
`default_nettype none

module hl_core_top
  import hl_core_pkg::*;
#(
  parameter int CMD_FIFO_DEPTH  = 4,
  parameter int RESP_FIFO_DEPTH = 4
) (
  input  logic       clk_ctrl,
  input  logic       reset_i,
  input  logic [7:0] host_byte_i,
  input  logic       host_byte_valid_i,
  input  logic [1:0] linkrx_i,
  input  logic       tx_inhibit_i,
  input  logic       resp_pop_i,
  output logic       run_o,
  output logic       tx_on_o,
  output logic [3:0] led_o,
  output logic       resp_valid_o,
  output resp_t      resp_o
);

  logic     host_push;
  cmd_req_t host_req;
  logic     host_full;
  logic     host_empty;
  logic     host_pop;
  cmd_req_t host_head;

  logic     link_push;
  cmd_req_t link_req;
  logic     link_full;
  logic     link_empty;
  logic     link_pop;
  cmd_req_t link_head;

  logic     bus_strobe;
  cmd_req_t bus_cmd;

  logic     resp_push;
  resp_t    resp_word;
  logic     resp_full;
  logic     resp_empty;

  ////////////////////////////////////////
  // command sources
  ////////////////////////////////////////

  host_cmd_parser i_host_cmd_parser (
    .clk_ctrl          (clk_ctrl),
    .reset_i           (reset_i),
    .host_byte_i       (host_byte_i),
    .host_byte_valid_i (host_byte_valid_i),
    .cmd_full_i        (host_full),
    .cmd_push_o        (host_push),
    .cmd_o             (host_req)
  );

  sync_fifo #(
    .payload_t (cmd_req_t),
    .DEPTH     (CMD_FIFO_DEPTH)
  ) i_host_fifo (
    .clk_ctrl (clk_ctrl),
    .reset_i  (reset_i),
    .push_i   (host_push),
    .data_i   (host_req),
    .pop_i    (host_pop),
    .data_o   (host_head),
    .empty_o  (host_empty),
    .full_o   (host_full)
  );

  link_cmd_rx i_link_cmd_rx (
    .clk_ctrl   (clk_ctrl),
    .reset_i    (reset_i),
    .linkrx_i   (linkrx_i),
    .cmd_full_i (link_full),
    .cmd_push_o (link_push),
    .cmd_o      (link_req)
  );

  sync_fifo #(
    .payload_t (cmd_req_t),
    .DEPTH     (CMD_FIFO_DEPTH)
  ) i_link_fifo (
    .clk_ctrl (clk_ctrl),
    .reset_i  (reset_i),
    .push_i   (link_push),
    .data_i   (link_req),
    .pop_i    (link_pop),
    .data_o   (link_head),
    .empty_o  (link_empty),
    .full_o   (link_full)
  );

  ////////////////////////////////////////
  // shared bus and slave
  ////////////////////////////////////////

  cmd_bus_arbiter i_cmd_bus_arbiter (
    .clk_ctrl     (clk_ctrl),
    .reset_i      (reset_i),
    .host_empty_i (host_empty),
    .link_empty_i (link_empty),
    .resp_full_i  (resp_full),
    .host_cmd_i   (host_head),
    .link_cmd_i   (link_head),
    .host_pop_o   (host_pop),
    .link_pop_o   (link_pop),
    .cmd_strobe_o (bus_strobe),
    .cmd_o        (bus_cmd)
  );

  radio_ctrl_regs i_radio_ctrl_regs (
    .clk_ctrl     (clk_ctrl),
    .reset_i      (reset_i),
    .cmd_strobe_i (bus_strobe),
    .cmd_i        (bus_cmd),
    .tx_inhibit_i (tx_inhibit_i),
    .run_o        (run_o),
    .tx_on_o      (tx_on_o),
    .led_o        (led_o),
    .resp_push_o  (resp_push),
    .resp_o       (resp_word)
  );

  sync_fifo #(
    .payload_t (resp_t),
    .DEPTH     (RESP_FIFO_DEPTH)
  ) i_resp_fifo (
    .clk_ctrl (clk_ctrl),
    .reset_i  (reset_i),
    .push_i   (resp_push),
    .data_i   (resp_word),
    .pop_i    (resp_pop_i),
    .data_o   (resp_o),
    .empty_o  (resp_empty),
    .full_o   (resp_full)
  );

  assign resp_valid_o = ~resp_empty;

endmodule

`default_nettype wire

//--- hw/radio_ctrl_regs.sv
/*
  Radio control register bank.
  Command slave holding run, transmit request and LED pattern, with
  transmit inhibit applied and readback responses on request.
*/
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_regs
  import hl_core_pkg::*;
(
  input  logic       clk_ctrl,
  input  logic       reset_i,
  input  logic       cmd_strobe_i,
  input  cmd_req_t   cmd_i,
  input  logic       tx_inhibit_i,
  output logic       run_o,
  output logic       tx_on_o,
  output logic [3:0] led_o,
  output logic       resp_push_o,
  output resp_t      resp_o
);

  logic [CMD_DATA_W-1:0] general_q;
  logic [CMD_DATA_W-1:0] tx_ctrl_q;
  logic [CMD_DATA_W-1:0] led_q;
  logic [CMD_ADDR_W-1:0] rd_addr_q;
  logic [CMD_DATA_W-1:0] rd_data;

  ////////////////////////////////////////
  // address decode and registers
  ////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      general_q <= '0;
      tx_ctrl_q <= '0;
      led_q     <= '0;
    end else if (cmd_strobe_i) begin
      case (cmd_i.addr)
        ADDR_GENERAL: general_q <= cmd_i.data;
        ADDR_TX_CTRL: tx_ctrl_q <= cmd_i.data;
        ADDR_LED:     led_q     <= cmd_i.data;
        default:      ;
      endcase
    end
  end

  assign run_o = general_q[0];
  assign led_o = led_q[3:0];

  // keying needs run and no external inhibit
  assign tx_on_o = tx_ctrl_q[0] & general_q[0] & ~tx_inhibit_i;

  ////////////////////////////////////////
  // readback
  ////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      resp_push_o <= 1'b0;
    end else begin
      resp_push_o <= cmd_strobe_i & cmd_i.resp_rqst;
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (cmd_strobe_i) begin
      rd_addr_q <= cmd_i.addr;
    end
  end

  // registers already hold the written value in the push cycle
  always_comb begin
    case (rd_addr_q)
      ADDR_GENERAL: rd_data = general_q;
      ADDR_TX_CTRL: rd_data = tx_ctrl_q;
      ADDR_LED:     rd_data = led_q;
      default:      rd_data = '0;
    endcase
  end

  assign resp_o.addr = rd_addr_q;
  assign resp_o.data = rd_data;

endmodule

`default_nettype wire

//--- hw/cmd_bus_arbiter.sv
/*
  Command bus arbiter.
  Round-robin grant between the host and link command queues onto
  the shared command bus, held off while the response queue is full.
*/
`timescale 1ns/1ps
`default_nettype none

module cmd_bus_arbiter
  import hl_core_pkg::*;
(
  input  logic     clk_ctrl,
  input  logic     reset_i,
  input  logic     host_empty_i,
  input  logic     link_empty_i,
  input  logic     resp_full_i,
  input  cmd_req_t host_cmd_i,
  input  cmd_req_t link_cmd_i,
  output logic     host_pop_o,
  output logic     link_pop_o,
  output logic     cmd_strobe_o,
  output cmd_req_t cmd_o
);

  cmd_src_e rr_q;
  logic     host_wait;
  logic     link_wait;
  logic     pick_host;
  logic     pick_link;

  assign host_wait = ~host_empty_i;
  assign link_wait = ~link_empty_i;

  // host wins when alone or when it holds the turn
  assign pick_host = host_wait & (~link_wait | (rr_q == SRC_HOST));
  assign pick_link = link_wait & ~pick_host;

  assign host_pop_o = pick_host & ~resp_full_i;
  assign link_pop_o = pick_link & ~resp_full_i;

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      rr_q         <= SRC_HOST;
      cmd_strobe_o <= 1'b0;
    end else begin
      cmd_strobe_o <= host_pop_o | link_pop_o;
      // turn passes to the other source after each grant
      if (host_pop_o) begin
        rr_q <= SRC_LINK;
      end else if (link_pop_o) begin
        rr_q <= SRC_HOST;
      end
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (host_pop_o) begin
      cmd_o <= host_cmd_i;
    end else if (link_pop_o) begin
      cmd_o <= link_cmd_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/link_cmd_rx.sv
/*
  Board-to-board link receiver.
  Shifts in serial command frames from the two-wire link and queues
  a frame only when exactly one command's worth of bits arrived.
*/
`timescale 1ns/1ps
`default_nettype none

module link_cmd_rx
  import hl_core_pkg::*;
(
  input  logic       clk_ctrl,
  input  logic       reset_i,
  input  logic [1:0] linkrx_i,
  input  logic       cmd_full_i,
  output logic       cmd_push_o,
  output cmd_req_t   cmd_o
);

  // one spare count so long frames stay distinguishable
  localparam int CNT_W = $clog2(LINK_FRAME_BITS + 2);

  logic [LINK_FRAME_BITS-1:0] shift_q;
  logic [CNT_W-1:0]           bit_cnt_q;
  logic                       link_en;
  logic                       link_bit;
  logic                       frame_end;
  logic                       len_ok;

  assign link_en  = linkrx_i[1];
  assign link_bit = linkrx_i[0];

  // counter is cleared while idle, so a nonzero count with enable low
  // marks the first cycle after a frame
  assign frame_end = ~link_en & (bit_cnt_q != '0);
  assign len_ok    = (bit_cnt_q == CNT_W'(LINK_FRAME_BITS));

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      bit_cnt_q <= '0;
    end else if (link_en) begin
      if (bit_cnt_q != CNT_W'(LINK_FRAME_BITS + 1)) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end else begin
      bit_cnt_q <= '0;
    end
  end

  // MSB first in cmd_req_t order
  always_ff @(posedge clk_ctrl) begin
    if (link_en) begin
      shift_q <= {shift_q[LINK_FRAME_BITS-2:0], link_bit};
    end
  end

  assign cmd_o      = cmd_req_t'(shift_q);
  assign cmd_push_o = frame_end & len_ok & ~cmd_full_i;

endmodule

`default_nettype wire

//--- hw/host_cmd_parser.sv
/*
  Host command parser.
  Hunts for the sync byte in the host byte stream, collects the control
  byte and four data bytes, and queues the assembled command.
*/
`timescale 1ns/1ps
`default_nettype none

module host_cmd_parser
  import hl_core_pkg::*;
(
  input  logic       clk_ctrl,
  input  logic       reset_i,
  input  logic [7:0] host_byte_i,
  input  logic       host_byte_valid_i,
  input  logic       cmd_full_i,
  output logic       cmd_push_o,
  output cmd_req_t   cmd_o
);

  typedef enum logic [1:0] {
    ST_SYNC,
    ST_CTRL,
    ST_DATA
  } state_e;

  state_e                state_q;
  logic [1:0]            byte_cnt_q;
  logic                  frame_done_q;
  logic                  rqst_q;
  logic [CMD_ADDR_W-1:0] addr_q;
  logic [CMD_DATA_W-1:0] data_q;

  ////////////////////////////////////////
  // frame FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      state_q      <= ST_SYNC;
      byte_cnt_q   <= '0;
      frame_done_q <= 1'b0;
    end else begin
      frame_done_q <= 1'b0;
      if (host_byte_valid_i) begin
        case (state_q)
          // anything but sync is noise here
          ST_SYNC: begin
            if (host_byte_i == FRAME_SYNC) begin
              state_q <= ST_CTRL;
            end
          end
          ST_CTRL: begin
            state_q    <= ST_DATA;
            byte_cnt_q <= '0;
          end
          ST_DATA: begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (byte_cnt_q == 2'd3) begin
              state_q      <= ST_SYNC;
              frame_done_q <= 1'b1;
            end
          end
          default: begin
            state_q <= ST_SYNC;
          end
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // command assembly
  ////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (host_byte_valid_i && state_q == ST_CTRL) begin
      rqst_q <= host_byte_i[0];
      addr_q <= host_byte_i[6:1];
    end
    // data arrives most significant byte first
    if (host_byte_valid_i && state_q == ST_DATA) begin
      data_q <= {data_q[CMD_DATA_W-9:0], host_byte_i};
    end
  end

  assign cmd_o.resp_rqst = rqst_q;
  assign cmd_o.addr      = addr_q;
  assign cmd_o.data      = data_q;

  // no room in the queue drops the frame
  assign cmd_push_o = frame_done_q & ~cmd_full_i;

endmodule

`default_nettype wire

//--- hw/sync_fifo.sv
/*
  Single-clock FIFO.
  Circular buffer with a type parameter for the payload, shared by
  the command queues and the response queue.
*/
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk_ctrl,
  input  logic     reset_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));

  // requests against the wrong state are dropped here
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  assign data_o = mem[rd_ptr_q];

  always_ff @(posedge clk_ctrl) begin
    if (do_push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // both at once leave the level alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/hl_core_pkg.sv
/*
  Transceiver core command path definitions.
  Shared command and response types, the register address map
  and the framing constants of the host and link command sources.
*/
`default_nettype none

package hl_core_pkg;

  ////////////////////////////////////////
  // command bus
  ////////////////////////////////////////

  localparam int CMD_ADDR_W = 6;
  localparam int CMD_DATA_W = 32;

  // one command as carried on the shared bus, 39 bits
  typedef struct packed {
    logic                  resp_rqst;
    logic [CMD_ADDR_W-1:0] addr;
    logic [CMD_DATA_W-1:0] data;
  } cmd_req_t;

  // readback word, 38 bits
  typedef struct packed {
    logic [CMD_ADDR_W-1:0] addr;
    logic [CMD_DATA_W-1:0] data;
  } resp_t;

  // command sources sharing the bus
  typedef enum logic {
    SRC_HOST,
    SRC_LINK
  } cmd_src_e;

  ////////////////////////////////////////
  // framing
  ////////////////////////////////////////

  localparam logic [7:0] FRAME_SYNC      = 8'h7F;
  localparam int         LINK_FRAME_BITS = 39;

  ////////////////////////////////////////
  // register map
  ////////////////////////////////////////

  // bit 0 is run
  localparam logic [CMD_ADDR_W-1:0] ADDR_GENERAL = 6'h00;
  // bit 0 is the transmit request
  localparam logic [CMD_ADDR_W-1:0] ADDR_TX_CTRL = 6'h09;
  // bits 3:0 drive the LEDs
  localparam logic [CMD_ADDR_W-1:0] ADDR_LED     = 6'h12;

endpackage

`default_nettype wire
